// ==== Makefile ====
TOP = tb_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f filelist.f

run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
source/cpu_pkg.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/mips_core.sv
testbench/tb_core.sv

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0]       RESET_PC  = 32'hbfc0_0000;
    localparam logic [XLEN-1:0]       PHYS_MASK = 32'h1fff_ffff;  // kseg0/kseg1 fold to physical
    localparam logic [REG_ADDR_W-1:0] LINK_REG  = 5'd31;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_AND  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_NOR  = 4'd5;
    localparam logic [3:0] ALU_SLT  = 4'd6;
    localparam logic [3:0] ALU_SLTU = 4'd7;
    localparam logic [3:0] ALU_SLL  = 4'd8;
    localparam logic [3:0] ALU_SRL  = 4'd9;
    localparam logic [3:0] ALU_SRA  = 4'd10;
    localparam logic [3:0] ALU_LUI  = 4'd11;

    // access size, same as the low two opcode bits of loads and stores
    localparam logic [1:0] SIZE_B = 2'b00;
    localparam logic [1:0] SIZE_H = 2'b01;
    localparam logic [1:0] SIZE_W = 2'b11;

    localparam logic [1:0] IMM_SIGN  = 2'd0;
    localparam logic [1:0] IMM_ZERO  = 2'd1;
    localparam logic [1:0] IMM_UPPER = 2'd2;  // lui

    typedef union packed {
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            op;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0]           imm16;
        } i;
    } instr_t;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::XLEN-1:0]       inst_addr,
    input  logic [cpu_pkg::XLEN-1:0]       inst_rdata,
    input  logic                           ex_fwd_wen,
    input  logic                           ex_fwd_load,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_fwd_wnum,
    input  logic [cpu_pkg::XLEN-1:0]       ex_fwd_data,
    input  logic                           wb_fwd_wen,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_fwd_wnum,
    input  logic [cpu_pkg::XLEN-1:0]       wb_fwd_data,
    output logic                           stall,
    output logic                           branch_take,
    output logic [cpu_pkg::XLEN-1:0]       branch_target,
    output logic [cpu_pkg::XLEN-1:0]       id_pc,
    output logic [cpu_pkg::XLEN-1:0]       id_inst,
    output logic [cpu_pkg::XLEN-1:0]       id_a,
    output logic [cpu_pkg::XLEN-1:0]       id_b,
    output logic [cpu_pkg::XLEN-1:0]       id_imm,
    output logic                           id_use_imm,
    output logic [3:0]                     id_alu_op,
    output logic                           id_regwen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] id_wnum,
    output logic                           id_link,
    output logic                           id_load,
    output logic                           id_load_signed,
    output logic [1:0]                     id_size,
    output logic                           id_store
);

    cpu_pkg::instr_t                inst;
    logic                           valid_q;  // low for the word read while in reset
    logic                           replay_q; // instruction kept through a stall
    logic [cpu_pkg::XLEN-1:0]       held_q;
    logic [cpu_pkg::XLEN-1:0]       rf_rs;
    logic [cpu_pkg::XLEN-1:0]       rf_rt;
    logic [cpu_pkg::XLEN-1:0]       pc_plus4;
    logic [cpu_pkg::REG_ADDR_W-1:0] wnum;
    logic [1:0]                     imm_kind;
    logic                           wen;
    logic                           is_beq;
    logic                           is_bne;
    logic                           is_jump;
    logic                           is_jr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            replay_q <= 1'b0;
        end else begin
            valid_q  <= 1'b1;
            replay_q <= stall;
        end
        if (!stall)
            id_pc <= inst_addr;
        held_q <= inst;
    end

    // the sram has already moved on when a stalled word is needed again
    assign inst    = !valid_q ? '0 : (replay_q ? held_q : inst_rdata);
    assign id_inst = inst;

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (inst.r.rs),
        .rt      (inst.r.rt),
        .wnum    (wb_fwd_wnum),
        .wen     (wb_fwd_wen),
        .wdata   (wb_fwd_data),
        .rs_data (rf_rs),
        .rt_data (rf_rt)
    );

    always_comb begin
        wen        = 1'b0;
        wnum       = inst.r.rt;
        id_alu_op  = cpu_pkg::ALU_ADD;
        id_use_imm = 1'b1;
        imm_kind   = cpu_pkg::IMM_SIGN;
        id_link    = 1'b0;
        id_load    = 1'b0;
        id_store   = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        is_jump    = 1'b0;
        is_jr      = 1'b0;
        case (inst.r.op)
            cpu_pkg::OP_SPECIAL: begin
                wnum       = inst.r.rd;
                id_use_imm = 1'b0;
                wen        = 1'b1;
                case (inst.r.funct)
                    cpu_pkg::FN_ADDU: id_alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUBU: id_alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  id_alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   id_alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  id_alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_NOR:  id_alu_op = cpu_pkg::ALU_NOR;
                    cpu_pkg::FN_SLT:  id_alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLTU: id_alu_op = cpu_pkg::ALU_SLTU;
                    cpu_pkg::FN_SLL:  id_alu_op = cpu_pkg::ALU_SLL;
                    cpu_pkg::FN_SRL:  id_alu_op = cpu_pkg::ALU_SRL;
                    cpu_pkg::FN_SRA:  id_alu_op = cpu_pkg::ALU_SRA;
                    cpu_pkg::FN_JR: begin
                        wen   = 1'b0;
                        is_jr = 1'b1;
                    end
                    default: wen = 1'b0;  // unsupported, no-op
                endcase
            end
            cpu_pkg::OP_ADDIU: wen = 1'b1;
            cpu_pkg::OP_SLTI: begin
                wen       = 1'b1;
                id_alu_op = cpu_pkg::ALU_SLT;
            end
            cpu_pkg::OP_SLTIU: begin
                wen       = 1'b1;
                id_alu_op = cpu_pkg::ALU_SLTU;
            end
            cpu_pkg::OP_ANDI: begin
                wen       = 1'b1;
                id_alu_op = cpu_pkg::ALU_AND;
                imm_kind  = cpu_pkg::IMM_ZERO;
            end
            cpu_pkg::OP_ORI: begin
                wen       = 1'b1;
                id_alu_op = cpu_pkg::ALU_OR;
                imm_kind  = cpu_pkg::IMM_ZERO;
            end
            cpu_pkg::OP_XORI: begin
                wen       = 1'b1;
                id_alu_op = cpu_pkg::ALU_XOR;
                imm_kind  = cpu_pkg::IMM_ZERO;
            end
            cpu_pkg::OP_LUI: begin
                wen       = 1'b1;
                id_alu_op = cpu_pkg::ALU_LUI;
                imm_kind  = cpu_pkg::IMM_UPPER;
            end
            cpu_pkg::OP_LB, cpu_pkg::OP_LH, cpu_pkg::OP_LW,
            cpu_pkg::OP_LBU, cpu_pkg::OP_LHU: begin
                wen     = 1'b1;
                id_load = 1'b1;
            end
            cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: id_store = 1'b1;
            cpu_pkg::OP_BEQ: is_beq = 1'b1;
            cpu_pkg::OP_BNE: is_bne = 1'b1;
            cpu_pkg::OP_J:   is_jump = 1'b1;
            cpu_pkg::OP_JAL: begin
                is_jump = 1'b1;
                wen     = 1'b1;
                id_link = 1'b1;
                wnum    = cpu_pkg::LINK_REG;
            end
            default: wen = 1'b0;
        endcase
    end

    assign id_load_signed = !inst.r.op[2];  // lb, lh
    assign id_size        = inst.r.op[1:0];
    assign id_wnum        = wnum;
    assign id_regwen      = wen && wnum != '0 && !stall;  // bubble while stalled

    always_comb begin
        case (imm_kind)
            cpu_pkg::IMM_ZERO:  id_imm = {16'b0, inst.i.imm16};
            cpu_pkg::IMM_UPPER: id_imm = {inst.i.imm16, 16'b0};
            default:            id_imm = {{16{inst.i.imm16[15]}}, inst.i.imm16};
        endcase
    end

    // execute result wins over writeback, it is younger
    assign id_a = (ex_fwd_wen && ex_fwd_wnum == inst.r.rs) ? ex_fwd_data :
                  (wb_fwd_wen && wb_fwd_wnum == inst.r.rs) ? wb_fwd_data : rf_rs;
    assign id_b = (ex_fwd_wen && ex_fwd_wnum == inst.r.rt) ? ex_fwd_data :
                  (wb_fwd_wen && wb_fwd_wnum == inst.r.rt) ? wb_fwd_data : rf_rt;

    // load data is not back until writeback
    assign stall = ex_fwd_wen && ex_fwd_load &&
                   (((is_beq || is_bne || is_jr) && ex_fwd_wnum == inst.r.rs) ||
                    ((is_beq || is_bne) && ex_fwd_wnum == inst.r.rt));

    assign pc_plus4    = id_pc + 32'd4;
    assign branch_take = !stall && ((is_beq && id_a == id_b) || (is_bne && id_a != id_b) ||
                                    is_jump || is_jr);
    assign branch_target = is_jr   ? id_a :
                           is_jump ? {pc_plus4[31:28], inst[25:0], 2'b00} :
                                     pc_plus4 + {id_imm[29:0], 2'b00};

    // a redirect during a stall would drop the replayed branch
    assert property (@(posedge clk) disable iff (!rst_n) !(branch_take && stall))
        else $error("branch taken while stalled");

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::XLEN-1:0]       id_pc,
    input  logic [cpu_pkg::XLEN-1:0]       id_inst,
    input  logic [cpu_pkg::XLEN-1:0]       id_a,
    input  logic [cpu_pkg::XLEN-1:0]       id_b,
    input  logic [cpu_pkg::XLEN-1:0]       id_imm,
    input  logic                           id_use_imm,
    input  logic [3:0]                     id_alu_op,
    input  logic                           id_regwen,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] id_wnum,
    input  logic                           id_link,
    input  logic                           id_load,
    input  logic                           id_load_signed,
    input  logic [1:0]                     id_size,
    input  logic                           id_store,
    input  logic                           wb_fwd_wen,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_fwd_wnum,
    input  logic [cpu_pkg::XLEN-1:0]       wb_fwd_data,
    output logic                           data_en,
    output logic [3:0]                     data_wen,
    output logic [cpu_pkg::XLEN-1:0]       data_addr,
    output logic [cpu_pkg::XLEN-1:0]       data_wdata,
    output logic                           ex_fwd_wen,
    output logic                           ex_fwd_load,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_fwd_wnum,
    output logic [cpu_pkg::XLEN-1:0]       ex_fwd_data,
    output logic [cpu_pkg::XLEN-1:0]       ex_pc,
    output logic [cpu_pkg::XLEN-1:0]       ex_result,
    output logic                           ex_regwen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_wnum,
    output logic                           ex_load,
    output logic                           ex_load_signed,
    output logic [1:0]                     ex_size,
    output logic [1:0]                     ex_addr_low
);

    cpu_pkg::instr_t          inst_q;
    logic [cpu_pkg::XLEN-1:0] a_q;
    logic [cpu_pkg::XLEN-1:0] b_q;
    logic [cpu_pkg::XLEN-1:0] imm_q;
    logic                     use_imm_q;
    logic [3:0]               alu_op_q;
    logic                     link_q;
    logic                     store_q;
    logic [cpu_pkg::XLEN-1:0] a;
    logic [cpu_pkg::XLEN-1:0] b;
    logic [cpu_pkg::XLEN-1:0] opb;
    logic [cpu_pkg::XLEN-1:0] alu;
    logic [3:0]               lane_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_regwen <= 1'b0;
            ex_load   <= 1'b0;
            store_q   <= 1'b0;
        end else begin
            ex_regwen <= id_regwen;
            ex_load   <= id_load;
            store_q   <= id_store;
        end
        ex_pc          <= id_pc;
        inst_q         <= id_inst;
        a_q            <= id_a;
        b_q            <= id_b;
        imm_q          <= id_imm;
        use_imm_q      <= id_use_imm;
        alu_op_q       <= id_alu_op;
        ex_wnum        <= id_wnum;
        link_q         <= id_link;
        ex_load_signed <= id_load_signed;
        ex_size        <= id_size;
    end

    // writeback retires the producer this cycle
    assign a   = (wb_fwd_wen && wb_fwd_wnum == inst_q.r.rs) ? wb_fwd_data : a_q;
    assign b   = (wb_fwd_wen && wb_fwd_wnum == inst_q.r.rt) ? wb_fwd_data : b_q;
    assign opb = use_imm_q ? imm_q : b;

    always_comb begin
        case (alu_op_q)
            cpu_pkg::ALU_SUB:  alu = a - opb;
            cpu_pkg::ALU_AND:  alu = a & opb;
            cpu_pkg::ALU_OR:   alu = a | opb;
            cpu_pkg::ALU_XOR:  alu = a ^ opb;
            cpu_pkg::ALU_NOR:  alu = ~(a | opb);
            cpu_pkg::ALU_SLT:  alu = {31'b0, $signed(a) < $signed(opb)};
            cpu_pkg::ALU_SLTU: alu = {31'b0, a < opb};
            cpu_pkg::ALU_SLL:  alu = b << inst_q.r.shamt;
            cpu_pkg::ALU_SRL:  alu = b >> inst_q.r.shamt;
            cpu_pkg::ALU_SRA:  alu = $signed(b) >>> inst_q.r.shamt;
            cpu_pkg::ALU_LUI:  alu = opb;
            default:           alu = a + opb;  // addu, addiu, address
        endcase
    end

    assign ex_result = link_q ? ex_pc + 32'd8 : alu;

    assign data_addr   = alu & cpu_pkg::PHYS_MASK;
    assign data_en     = ex_load || store_q;
    assign lane_mask   = (ex_size == cpu_pkg::SIZE_B) ? 4'b0001 :
                         (ex_size == cpu_pkg::SIZE_H) ? 4'b0011 : 4'b1111;
    assign data_wen    = store_q ? lane_mask << data_addr[1:0] : 4'b0000;
    assign data_wdata  = b << {data_addr[1:0], 3'b000};
    assign ex_addr_low = data_addr[1:0];

    assign ex_fwd_wen  = ex_regwen;
    assign ex_fwd_load = ex_load;
    assign ex_fwd_wnum = ex_wnum;
    assign ex_fwd_data = ex_result;  // meaningless for a load, decode stalls on it

    assert property (@(posedge clk) disable iff (!rst_n) (data_wen != 4'b0000) |-> data_en)
        else $error("byte enables without data_en");

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     branch_take,
    input  logic [cpu_pkg::XLEN-1:0] branch_target,
    output logic [cpu_pkg::XLEN-1:0] inst_addr
);

    logic [cpu_pkg::XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= cpu_pkg::RESET_PC;
        end else if (branch_take) begin
            pc <= branch_target;  // delay slot already fetched
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign inst_addr = pc;

    // targets come from decode and from register values via jr
    assert property (@(posedge clk) disable iff (!rst_n) inst_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_core (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [cpu_pkg::XLEN-1:0]       inst_addr,
    input  logic [cpu_pkg::XLEN-1:0]       inst_rdata,
    output logic                           data_en,
    output logic [3:0]                     data_wen,
    output logic [cpu_pkg::XLEN-1:0]       data_addr,
    output logic [cpu_pkg::XLEN-1:0]       data_wdata,
    input  logic [cpu_pkg::XLEN-1:0]       data_rdata,
    output logic [cpu_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::XLEN-1:0]       debug_wb_rf_wdata
);

    // fetch and decode
    logic                           stall;
    logic                           branch_take;
    logic [cpu_pkg::XLEN-1:0]       branch_target;

    // decode to execute
    logic [cpu_pkg::XLEN-1:0]       id_pc;
    logic [cpu_pkg::XLEN-1:0]       id_inst;
    logic [cpu_pkg::XLEN-1:0]       id_a;
    logic [cpu_pkg::XLEN-1:0]       id_b;
    logic [cpu_pkg::XLEN-1:0]       id_imm;
    logic                           id_use_imm;
    logic [3:0]                     id_alu_op;
    logic                           id_regwen;
    logic [cpu_pkg::REG_ADDR_W-1:0] id_wnum;
    logic                           id_link;
    logic                           id_load;
    logic                           id_load_signed;
    logic [1:0]                     id_size;
    logic                           id_store;

    // execute forward path and execute to writeback
    logic                           ex_fwd_wen;
    logic                           ex_fwd_load;
    logic [cpu_pkg::REG_ADDR_W-1:0] ex_fwd_wnum;
    logic [cpu_pkg::XLEN-1:0]       ex_fwd_data;
    logic [cpu_pkg::XLEN-1:0]       ex_pc;
    logic [cpu_pkg::XLEN-1:0]       ex_result;
    logic                           ex_regwen;
    logic [cpu_pkg::REG_ADDR_W-1:0] ex_wnum;
    logic                           ex_load;
    logic                           ex_load_signed;
    logic [1:0]                     ex_size;
    logic [1:0]                     ex_addr_low;

    // writeback to register file and both forward muxes
    logic                           wb_fwd_wen;
    logic [cpu_pkg::REG_ADDR_W-1:0] wb_fwd_wnum;
    logic [cpu_pkg::XLEN-1:0]       wb_fwd_data;

    fetch_stage fetch_stage_i (.*);

    decode_stage decode_stage_i (.*);

    execute_stage execute_stage_i (.*);

    writeback_stage writeback_stage_i (.*);

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rt,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wnum,
    input  logic                           wen,
    input  logic [cpu_pkg::XLEN-1:0]       wdata,
    output logic [cpu_pkg::XLEN-1:0]       rs_data,
    output logic [cpu_pkg::XLEN-1:0]       rt_data
);

    logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 2**cpu_pkg::REG_ADDR_W; k++)
                regs[k] <= '0;
        end else if (wen && wnum != '0) begin
            regs[wnum] <= wdata;
        end
    end

    // $zero is hardwired
    assign rs_data = (rs == '0) ? '0 : regs[rs];
    assign rt_data = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::XLEN-1:0]       ex_pc,
    input  logic [cpu_pkg::XLEN-1:0]       ex_result,
    input  logic                           ex_regwen,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_wnum,
    input  logic                           ex_load,
    input  logic                           ex_load_signed,
    input  logic [1:0]                     ex_size,
    input  logic [1:0]                     ex_addr_low,
    input  logic [cpu_pkg::XLEN-1:0]       data_rdata,
    output logic                           wb_fwd_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_fwd_wnum,
    output logic [cpu_pkg::XLEN-1:0]       wb_fwd_data,
    output logic [cpu_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [cpu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::XLEN-1:0]       debug_wb_rf_wdata
);

    logic [cpu_pkg::XLEN-1:0]       pc_q;
    logic [cpu_pkg::XLEN-1:0]       result_q;
    logic                           regwen_q;
    logic [cpu_pkg::REG_ADDR_W-1:0] wnum_q;
    logic                           load_q;
    logic                           signed_q;
    logic [1:0]                     size_q;
    logic [1:0]                     addr_low_q;
    logic [cpu_pkg::XLEN-1:0]       shifted;
    logic [cpu_pkg::XLEN-1:0]       load_val;

    always_ff @(posedge clk) begin
        if (!rst_n)
            regwen_q <= 1'b0;
        else
            regwen_q <= ex_regwen;
        pc_q       <= ex_pc;
        result_q   <= ex_result;
        wnum_q     <= ex_wnum;
        load_q     <= ex_load;
        signed_q   <= ex_load_signed;
        size_q     <= ex_size;
        addr_low_q <= ex_addr_low;
    end

    assign shifted = data_rdata >> {addr_low_q, 3'b000};  // addressed byte to lane 0

    always_comb begin
        case (size_q)
            cpu_pkg::SIZE_B: load_val = {{24{signed_q & shifted[7]}}, shifted[7:0]};
            cpu_pkg::SIZE_H: load_val = {{16{signed_q & shifted[15]}}, shifted[15:0]};
            default:         load_val = shifted;
        endcase
    end

    assign wb_fwd_wen  = regwen_q;
    assign wb_fwd_wnum = wnum_q;
    assign wb_fwd_data = load_q ? load_val : result_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_wen   = {4{regwen_q}};
    assign debug_wb_rf_wnum  = wnum_q;
    assign debug_wb_rf_wdata = wb_fwd_data;

    // decode must have dropped every write to $zero
    assert property (@(posedge clk) disable iff (!rst_n)
        (debug_wb_rf_wen != 4'b0000) |-> (debug_wb_rf_wnum != '0))
        else $error("register write to $zero reached writeback");

endmodule

`default_nettype wire

// ==== testbench/core_testdata.txt ====
// program words from RESET_PC, then ffffffff
// then trace rows: name index, pc, register, value; ffffffff ends
3c018000 // lui   r1, 0x8000
34020100 // ori   r2, r0, 0x100
2423ffff // addiu r3, r1, -1
0023202a // slt   r4, r1, r3
0023282b // sltu  r5, r1, r3
00013103 // sra   r6, r1, 4
00013902 // srl   r7, r1, 4
00614023 // subu  r8, r3, r1
01064826 // xor   r9, r8, r6
282affff // slti  r10, r1, -1
ac470000 // sw    r7, 0(r2)
a0480000 // sb    r8, 0(r2)
a4480002 // sh    r8, 2(r2)
804b0000 // lb    r11, 0(r2)
904c0000 // lbu   r12, 0(r2)
844d0002 // lh    r13, 2(r2)
944e0002 // lhu   r14, 2(r2)
8c4f0000 // lw    r15, 0(r2)
15e00002 // bne   r15, r0, +2
24100005 // addiu r16, r0, 5
24110007 // addiu r17, r0, 7
12040003 // beq   r16, r4, +3
02049021 // addu  r18, r16, r4
0ff0001c // jal   word 28
34131234 // ori   r19, r0, 0x1234
24140009 // addiu r20, r0, 9
0bf0001a // j     word 26
00000000 // nop
3a7500ff // xori  r21, r19, 0xff
03e00008 // jr    r31
32b60f0f // andi  r22, r21, 0x0f0f
ffffffff
00000000 bfc00000 00000001 80000000
00000001 bfc00004 00000002 00000100
00000002 bfc00008 00000003 7fffffff
00000002 bfc0000c 00000004 00000001
00000001 bfc00010 00000005 00000000
00000001 bfc00014 00000006 f8000000
00000001 bfc00018 00000007 08000000
00000001 bfc0001c 00000008 ffffffff
00000002 bfc00020 00000009 07ffffff
00000001 bfc00024 0000000a 00000001
00000003 bfc00034 0000000b ffffffff
00000003 bfc00038 0000000c 000000ff
00000003 bfc0003c 0000000d ffffffff
00000003 bfc00040 0000000e 0000ffff
00000003 bfc00044 0000000f ffff00ff
00000005 bfc0004c 00000010 00000005
00000004 bfc00058 00000012 00000006
00000004 bfc0005c 0000001f bfc00064
00000004 bfc00060 00000013 00001234
00000002 bfc00070 00000015 000012cb
00000004 bfc00078 00000016 0000020b
00000004 bfc00064 00000014 00000009
ffffffff

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_core;

    logic                           clk;
    logic                           rst_n;
    logic [cpu_pkg::XLEN-1:0]       inst_addr;
    logic [cpu_pkg::XLEN-1:0]       inst_rdata;
    logic                           data_en;
    logic [3:0]                     data_wen;
    logic [cpu_pkg::XLEN-1:0]       data_addr;
    logic [cpu_pkg::XLEN-1:0]       data_wdata;
    logic [cpu_pkg::XLEN-1:0]       data_rdata;
    logic [cpu_pkg::XLEN-1:0]       debug_wb_pc;
    logic [3:0]                     debug_wb_rf_wen;
    logic [cpu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [cpu_pkg::XLEN-1:0]       debug_wb_rf_wdata;

    logic [31:0] tdata [256];  // program, separator, trace, terminator
    logic [31:0] dmem [64];
    logic [31:0] iaddr_q;       // fetch address seen one cycle ago
    string       names [6] = '{"reset", "alu", "forward", "mem", "branch", "stall"};
    int          n_prog;
    int          n_trace;
    int          trace_base;
    int          trace_idx;
    int          rd_idx;
    int          rst_cnt;
    int          cycles;
    int          limit;
    int          errors;

    mips_core dut_i (.*);

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int widx;
        widx = int'((addr - cpu_pkg::RESET_PC) >> 2);
        if (widx >= 0 && widx < n_prog)
            return tdata[widx];
        return 32'h0;  // nop outside the program
    endfunction

    // trace sampled on the edge that writes the register file
    always @(posedge clk) begin
        int    base;
        int    ni;
        string name;
        if (rst_n) begin
            cycles++;
            if (trace_idx == 0)
                check("reset", 32'h0, {31'b0, data_en});  // nothing touches memory yet
            if (debug_wb_rf_wen != 4'b0000) begin
                if (trace_idx >= n_trace) begin
                    $display("unexpected register write to r%0d after the trace ended",
                             debug_wb_rf_wnum);
                    errors++;
                end else begin
                    base = trace_base + 4 * trace_idx;
                    ni   = int'(tdata[base]);
                    name = (ni >= 0 && ni < 6) ? names[ni] : "unknown";
                    check(name, tdata[base + 1], debug_wb_pc);
                    check(name, tdata[base + 2], {27'b0, debug_wb_rf_wnum});
                    check(name, tdata[base + 3], debug_wb_rf_wdata);
                    trace_idx++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_cnt < 8) begin
            check("reset", 32'h0, {28'b0, debug_wb_rf_wen});
            check("reset", 32'h0, {31'b0, data_en});
            rst_cnt++;
            if (rst_cnt == 8)
                rst_n = 1'b1;
        end else begin
            data_rdata = dmem[rd_idx];  // read answered one cycle late
            if (data_en) begin
                rd_idx = int'(data_addr[7:2]);
                for (int b = 0; b < 4; b++) begin
                    if (data_wen[b])
                        dmem[rd_idx][8*b +: 8] = data_wdata[8*b +: 8];
                end
            end
        end
        inst_rdata = fetch_word(iaddr_q);
        iaddr_q    = inst_addr;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        iaddr_q    = cpu_pkg::RESET_PC;
        errors     = 0;
        trace_idx  = 0;
        rd_idx     = 0;
        rst_cnt    = 0;
        cycles     = 0;
        void'($urandom(32'ha16c));
        $readmemh("testbench/core_testdata.txt", tdata);

        n_prog = 0;
        while (n_prog < 255 && tdata[n_prog] != 32'hffff_ffff)
            n_prog++;
        trace_base = n_prog + 1;
        n_trace    = 0;
        while (trace_base + 4 * n_trace < 252 &&
               tdata[trace_base + 4 * n_trace] != 32'hffff_ffff)
            n_trace++;
        limit = 8 * n_trace + 50;

        // loads read back only word 0 at address 0x100
        for (int i = 0; i < 64; i++)
            dmem[i] = (i == 0) ? 32'h0 : $urandom();

        while (trace_idx < n_trace && cycles < limit)
            @(negedge clk);
        if (trace_idx < n_trace) begin
            $display("timeout: only %0d of %0d register writes arrived within %0d cycles",
                     trace_idx, n_trace, limit);
            errors++;
        end else begin
            repeat (10) @(negedge clk);  // catch stray writes after the trace
        end
        $display("errors: %0d, trace entries checked: %0d of %0d", errors, trace_idx, n_trace);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
